// ==== rtl/lsu_pipe_pkg.sv ====
package lsu_pipe_pkg;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_sltu = 3'd5,
        alu_sll  = 3'd6,
        alu_srl  = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        wsel_alu  = 2'd0,
        wsel_load = 2'd1,
        wsel_pc4  = 2'd2  // link value
    } wreg_sel_e;

    // riscv func3 load sizes
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_ld  = 3'b011;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_lwu = 3'b110;

    // store sizes share the low codes
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;
    localparam logic [2:0] f3_sd  = 3'b011;

    typedef struct packed {
        logic [63:0] pc;
        alu_op_e     alu_op;
        logic [63:0] src1;
        logic [63:0] src2;
        logic [63:0] imm;
        logic        use_imm;   // imm replaces src2 at the alu
        logic [4:0]  rd;
        logic        reg_wen;
        wreg_sel_e   wreg_sel;
        logic [2:0]  func3;
        logic        mem_ren;
        logic        mem_wen;
    } issue_op_t;

    typedef struct packed {
        logic [63:0] pc;
        logic [63:0] alu_result;  // also the memory address
        logic [63:0] store_data;
        logic [4:0]  rd;
        logic        reg_wen;
        wreg_sel_e   wreg_sel;
        logic [2:0]  func3;
        logic        mem_ren;
        logic        mem_wen;
    } ex_to_ms_t;

    typedef struct packed {
        logic [63:0] pc;
        logic [63:0] alu_result;
        logic [63:0] rdata;       // whole doubleword, aligned later
        logic [4:0]  rd;
        logic        reg_wen;
        wreg_sel_e   wreg_sel;
        logic [2:0]  func3;
    } ms_to_ws_t;

    typedef struct packed {
        logic [63:0] pc;
        logic [4:0]  rd;
        logic        reg_wen;
        logic [63:0] wdata;
    } retire_t;

    // one doubleword seen at each access size
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } dword_u;

endpackage

// ==== rtl/ex_stage.sv ====
module ex_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  lsu_pipe_pkg::issue_op_t in_op,
    output logic                   in_ready,
    input  logic                   ms_allowin,
    output logic                   out_valid,
    output lsu_pipe_pkg::ex_to_ms_t out_bus
);

    logic                    es_valid;
    lsu_pipe_pkg::issue_op_t es_op;    // held operation
    logic                    es_ready_go;
    logic [63:0]             op2;
    logic [5:0]              shamt;
    logic [63:0]             alu_out;
    logic [63:0]             mem_addr;
    logic                    is_mem;

    assign es_ready_go = 1'b1;          // single cycle alu
    assign in_ready    = !es_valid || (es_ready_go && ms_allowin);
    assign out_valid   = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (in_ready) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            es_op <= in_op;
        end
    end

    // second operand
    assign op2   = es_op.use_imm ? es_op.imm : es_op.src2;
    assign shamt = op2[5:0];            // rv64 shifts use six bits

    always_comb begin
        case (es_op.alu_op)
            lsu_pipe_pkg::alu_add:  alu_out = es_op.src1 + op2;
            lsu_pipe_pkg::alu_sub:  alu_out = es_op.src1 - op2;
            lsu_pipe_pkg::alu_and:  alu_out = es_op.src1 & op2;
            lsu_pipe_pkg::alu_or:   alu_out = es_op.src1 | op2;
            lsu_pipe_pkg::alu_xor:  alu_out = es_op.src1 ^ op2;
            lsu_pipe_pkg::alu_sltu: alu_out = {63'd0, es_op.src1 < op2};
            lsu_pipe_pkg::alu_sll:  alu_out = es_op.src1 << shamt;
            lsu_pipe_pkg::alu_srl:  alu_out = es_op.src1 >> shamt;
            default:                alu_out = '0;
        endcase
    end

    // loads and stores always address base plus offset
    assign is_mem   = es_op.mem_ren || es_op.mem_wen;
    assign mem_addr = es_op.src1 + es_op.imm;

    always_comb begin
        out_bus            = '0;
        out_bus.pc         = es_op.pc;
        out_bus.alu_result = is_mem ? mem_addr : alu_out;
        out_bus.store_data = es_op.src2;    // store value is always rs2
        out_bus.rd         = es_op.rd;
        out_bus.reg_wen    = es_op.reg_wen;
        out_bus.wreg_sel   = es_op.wreg_sel;
        out_bus.func3      = es_op.func3;
        out_bus.mem_ren    = es_op.mem_ren;
        out_bus.mem_wen    = es_op.mem_wen;
    end

endmodule

// ==== rtl/data_ram.sv ====
module data_ram #(
    parameter int RAM_DWORDS = 256
) (
    input  logic        clk,
    input  logic [63:0] raddr,
    output logic [63:0] rdata,
    input  logic        we,
    input  logic [63:0] waddr,
    input  logic [63:0] wdata,
    input  logic [2:0]  func3
);

    localparam int IDX_W = $clog2(RAM_DWORDS);

    logic [63:0] mem [RAM_DWORDS];

    logic [IDX_W-1:0]     ridx;
    logic [IDX_W-1:0]     widx;
    logic [2:0]           woff;
    lsu_pipe_pkg::dword_u old_word;
    lsu_pipe_pkg::dword_u new_word;

    // doubleword index wraps at the array size
    assign ridx = raddr[IDX_W+2:3];
    assign widx = waddr[IDX_W+2:3];
    assign woff = waddr[2:0];

    assign rdata = mem[ridx];   // combinational read

    // merge the store into the current doubleword
    always_comb begin
        old_word.d = mem[widx];
        new_word   = old_word;
        case (func3)
            lsu_pipe_pkg::f3_sb: begin
                new_word.b[woff] = wdata[7:0];
            end
            lsu_pipe_pkg::f3_sh: begin
                new_word.h[woff[2:1]] = wdata[15:0];  // low bit dropped
            end
            lsu_pipe_pkg::f3_sw: begin
                new_word.w[woff[2]] = wdata[31:0];
            end
            lsu_pipe_pkg::f3_sd: begin
                new_word.d = wdata;
            end
            default: begin
                new_word = old_word;    // not a store size, leave as is
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[widx] <= new_word.d;
        end
    end

endmodule

// ==== rtl/mem_stage.sv ====
module mem_stage #(
    parameter int RAM_DWORDS = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    es_to_ms_valid,
    input  lsu_pipe_pkg::ex_to_ms_t es_to_ms_bus,
    output logic                    ms_allowin,
    input  logic                    ws_allowin,
    output logic                    ms_to_ws_valid,
    output lsu_pipe_pkg::ms_to_ws_t ms_to_ws_bus
);

    logic                    ms_valid;
    lsu_pipe_pkg::ex_to_ms_t ms_bus;
    logic                    ms_ready_go;
    logic                    ms_leaving;
    logic                    ram_we;
    logic [63:0]             ram_rdata;

    assign ms_ready_go    = 1'b1;       // ram read is combinational
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    // the op hands over to writeback on this edge
    assign ms_leaving = ms_to_ws_valid && ws_allowin;

    // store commits only once, when it moves on
    assign ram_we = ms_leaving && ms_bus.mem_wen;

    data_ram #(
        .RAM_DWORDS(RAM_DWORDS)
    ) u_data_ram (
        .clk  (clk),
        .raddr(ms_bus.alu_result),
        .rdata(ram_rdata),
        .we   (ram_we),
        .waddr(ms_bus.alu_result),
        .wdata(ms_bus.store_data),
        .func3(ms_bus.func3)
    );

    always_comb begin
        ms_to_ws_bus            = '0;
        ms_to_ws_bus.pc         = ms_bus.pc;
        ms_to_ws_bus.alu_result = ms_bus.alu_result;
        // only loads carry ram data onward
        ms_to_ws_bus.rdata      = ms_bus.mem_ren ? ram_rdata : 64'd0;
        ms_to_ws_bus.rd         = ms_bus.rd;
        ms_to_ws_bus.reg_wen    = ms_bus.reg_wen && !ms_bus.mem_wen;  // stores never write rd
        ms_to_ws_bus.wreg_sel   = ms_bus.wreg_sel;
        ms_to_ws_bus.func3      = ms_bus.func3;
    end

endmodule

// ==== rtl/wb_stage.sv ====
module wb_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ms_to_ws_valid,
    input  lsu_pipe_pkg::ms_to_ws_t ms_to_ws_bus,
    output logic                    ws_allowin,
    input  logic                    retire_ready,
    output logic                    retire_valid,
    output lsu_pipe_pkg::retire_t   retire
);

    logic                    ws_valid;
    lsu_pipe_pkg::ms_to_ws_t ws_bus;
    logic                    ws_ready_go;
    lsu_pipe_pkg::dword_u    ld_word;
    logic [2:0]              off;
    logic [7:0]              ld_byte;
    logic [15:0]             ld_half;
    logic [31:0]             ld_word32;
    logic [63:0]             ld_value;
    logic [63:0]             link;
    logic [63:0]             wdata;

    assign ws_ready_go  = 1'b1;
    assign ws_allowin   = !ws_valid || (ws_ready_go && retire_ready);
    assign retire_valid = ws_valid && ws_ready_go;

    // record is held while retire_ready is low
    always_ff @(posedge clk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    // pick the field at the naturally aligned offset
    assign ld_word.d = ws_bus.rdata;
    assign off       = ws_bus.alu_result[2:0];
    assign ld_byte   = ld_word.b[off];
    assign ld_half   = ld_word.h[off[2:1]];
    assign ld_word32 = ld_word.w[off[2]];

    always_comb begin
        case (ws_bus.func3)
            lsu_pipe_pkg::f3_lb:  ld_value = {{56{ld_byte[7]}}, ld_byte};
            lsu_pipe_pkg::f3_lh:  ld_value = {{48{ld_half[15]}}, ld_half};
            lsu_pipe_pkg::f3_lw:  ld_value = {{32{ld_word32[31]}}, ld_word32};
            lsu_pipe_pkg::f3_ld:  ld_value = ld_word.d;
            lsu_pipe_pkg::f3_lbu: ld_value = {56'd0, ld_byte};
            lsu_pipe_pkg::f3_lhu: ld_value = {48'd0, ld_half};
            lsu_pipe_pkg::f3_lwu: ld_value = {32'd0, ld_word32};
            default:              ld_value = ld_word.d;   // 3'b111 unused
        endcase
    end

    assign link = ws_bus.pc + 64'd4;

    always_comb begin
        case (ws_bus.wreg_sel)
            lsu_pipe_pkg::wsel_alu:  wdata = ws_bus.alu_result;
            lsu_pipe_pkg::wsel_load: wdata = ld_value;
            lsu_pipe_pkg::wsel_pc4:  wdata = link;
            default:                 wdata = ws_bus.alu_result;
        endcase
    end

    always_comb begin
        retire         = '0;
        retire.pc      = ws_bus.pc;
        retire.rd      = ws_bus.rd;
        retire.reg_wen = ws_bus.reg_wen;
        retire.wdata   = wdata;
    end

endmodule

// ==== rtl/lsu_pipe_top.sv ====
module lsu_pipe_top #(
    parameter int RAM_DWORDS = 256     // power of two
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  lsu_pipe_pkg::issue_op_t issue_op,
    output logic                    issue_ready,
    output logic                    retire_valid,
    output lsu_pipe_pkg::retire_t   retire,
    input  logic                    retire_ready
);

    logic                    es_to_ms_valid;
    lsu_pipe_pkg::ex_to_ms_t es_to_ms_bus;
    logic                    ms_allowin;
    logic                    ms_to_ws_valid;
    lsu_pipe_pkg::ms_to_ws_t ms_to_ws_bus;
    logic                    ws_allowin;

    ex_stage u_ex_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (issue_valid),
        .in_op     (issue_op),
        .in_ready  (issue_ready),
        .ms_allowin(ms_allowin),
        .out_valid (es_to_ms_valid),
        .out_bus   (es_to_ms_bus)
    );

    mem_stage #(
        .RAM_DWORDS(RAM_DWORDS)
    ) u_mem_stage (
        .clk           (clk),
        .rst           (rst),
        .es_to_ms_valid(es_to_ms_valid),
        .es_to_ms_bus  (es_to_ms_bus),
        .ms_allowin    (ms_allowin),
        .ws_allowin    (ws_allowin),
        .ms_to_ws_valid(ms_to_ws_valid),
        .ms_to_ws_bus  (ms_to_ws_bus)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .rst           (rst),
        .ms_to_ws_valid(ms_to_ws_valid),
        .ms_to_ws_bus  (ms_to_ws_bus),
        .ws_allowin    (ws_allowin),
        .retire_ready  (retire_ready),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

// ==== dv/tb_lsu_pipe.sv ====
module tb_lsu_pipe;

    localparam int RAM_DWORDS  = 256;
    localparam int FILL_DWORDS = 64;     // region every test stays inside
    localparam int BP_OPS      = 300;
    localparam int MAX_CYCLES  = 6000;

    logic                    clk;
    logic                    rst;
    logic                    issue_valid;
    lsu_pipe_pkg::issue_op_t issue_op;
    logic                    issue_ready;
    logic                    retire_valid;
    lsu_pipe_pkg::retire_t   retire;
    logic                    retire_ready;

    integer                  seed;
    integer                  rnd_bit;
    string                   tname;
    logic [63:0]             pc_next;
    logic [63:0]             shadow [RAM_DWORDS];   // memory model
    lsu_pipe_pkg::retire_t   exp_q [$];
    lsu_pipe_pkg::retire_t   exp_rec;
    lsu_pipe_pkg::issue_op_t bp_ops [BP_OPS];
    int                      bp_gap [BP_OPS];
    int                      cycles;
    logic                    bp_on;

    lsu_pipe_top #(
        .RAM_DWORDS(RAM_DWORDS)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .retire_valid(retire_valid),
        .retire      (retire),
        .retire_ready(retire_ready)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            fail_run($sformatf("FAILED %s %s: expected %h actual %h", tname, what, exp, act));
        end
    endtask

    function automatic logic [63:0] rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    // every bit of the index moves the pattern
    function automatic logic [63:0] fill_word(input int idx);
        return (64'(idx) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    function automatic lsu_pipe_pkg::issue_op_t make_alu(input logic [2:0] code,
            input logic use_imm, input lsu_pipe_pkg::wreg_sel_e sel);
        lsu_pipe_pkg::issue_op_t op;
        logic [63:0]             r;
        r          = rand64();
        op         = '0;
        op.pc      = pc_next;
        pc_next    = pc_next + 64'd4;
        op.alu_op  = lsu_pipe_pkg::alu_op_e'(code);
        op.src1    = rand64();
        op.src2    = rand64();
        op.imm     = {{52{r[11]}}, r[11:0]};
        op.use_imm = use_imm;
        op.rd      = r[20:16];
        op.reg_wen = 1'b1;
        op.wreg_sel = sel;
        return op;
    endfunction

    // random high address bits make the ram index wrap
    function automatic lsu_pipe_pkg::issue_op_t make_mem(input logic is_store,
            input logic [2:0] f3, input logic [63:0] addr, input logic reg_wen);
        lsu_pipe_pkg::issue_op_t op;
        logic [63:0]             r;
        r           = rand64();
        op          = '0;
        op.pc       = pc_next;
        pc_next     = pc_next + 64'd4;
        op.alu_op   = lsu_pipe_pkg::alu_add;
        op.imm      = {{52{r[11]}}, r[11:0]};
        op.src1     = {r[63:48], 37'd0, addr[10:0]} - op.imm;
        op.src2     = rand64();
        op.rd       = r[20:16];
        op.reg_wen  = reg_wen;
        op.wreg_sel = is_store ? lsu_pipe_pkg::wsel_alu : lsu_pipe_pkg::wsel_load;
        op.func3    = f3;
        op.mem_ren  = !is_store;
        op.mem_wen  = is_store;
        return op;
    endfunction

    // builds the expected retire record and updates the shadow in program order
    task automatic model_issue(input lsu_pipe_pkg::issue_op_t op);
        logic [63:0]           op2;
        logic [63:0]           res;
        logic [63:0]           field;
        int                    idx;
        int                    nbytes;
        int                    off;
        int                    sh;
        int                    i;
        lsu_pipe_pkg::retire_t r;
        op2 = op.use_imm ? op.imm : op.src2;
        case (op.alu_op)
            lsu_pipe_pkg::alu_add:  res = op.src1 + op2;
            lsu_pipe_pkg::alu_sub:  res = op.src1 - op2;
            lsu_pipe_pkg::alu_and:  res = op.src1 & op2;
            lsu_pipe_pkg::alu_or:   res = op.src1 | op2;
            lsu_pipe_pkg::alu_xor:  res = op.src1 ^ op2;
            lsu_pipe_pkg::alu_sltu: res = (op.src1 < op2) ? 64'd1 : 64'd0;
            lsu_pipe_pkg::alu_sll:  res = op.src1 << op2[5:0];
            default:                res = op.src1 >> op2[5:0];
        endcase
        if (op.mem_ren || op.mem_wen) res = op.src1 + op.imm;
        idx    = int'((res >> 3) % RAM_DWORDS);
        nbytes = 1 << op.func3[1:0];
        off    = int'(res[2:0]) & ~(nbytes - 1);   // natural alignment
        if (op.mem_wen) begin
            for (i = 0; i < nbytes; i++) shadow[idx][(off + i) * 8 +: 8] = op.src2[i * 8 +: 8];
        end
        sh    = 64 - nbytes * 8;
        field = (shadow[idx] >> (off * 8)) << sh;
        if (op.func3[2]) field = field >> sh;
        else field = $signed(field) >>> sh;
        r.pc      = op.pc;
        r.rd      = op.rd;
        r.reg_wen = op.reg_wen && !op.mem_wen;
        case (op.wreg_sel)
            lsu_pipe_pkg::wsel_load: r.wdata = field;
            lsu_pipe_pkg::wsel_pc4:  r.wdata = op.pc + 64'd4;
            default:                 r.wdata = res;
        endcase
        exp_q.push_back(r);
    endtask

    // starts on a rising edge and returns on the transfer edge
    task automatic issue(input lsu_pipe_pkg::issue_op_t op);
        issue_valid <= 1'b1;
        issue_op    <= op;
        @(posedge clk);
        while (!issue_ready) @(posedge clk);
        model_issue(op);
    endtask

    task automatic drain();
        issue_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic test_reset();
        tname = "reset";
        @(posedge clk);
        repeat (7) begin
            @(posedge clk);
            check_value("retire_valid", 64'd0, retire_valid);
            check_value("issue_ready", 64'd1, issue_ready);
        end
        rst <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            check_value("retire_valid", 64'd0, retire_valid);
            check_value("issue_ready", 64'd1, issue_ready);
        end
    endtask

    task automatic test_alu();
        int code;
        tname = "alu";
        for (code = 0; code < 8; code++) begin
            issue(make_alu(3'(code), 1'b0, lsu_pipe_pkg::wsel_alu));
            issue(make_alu(3'(code), 1'b1, lsu_pipe_pkg::wsel_alu));
        end
        drain();
    endtask

    task automatic test_mem();
        lsu_pipe_pkg::issue_op_t op;
        logic [63:0]             r;
        int                      i;
        int                      f3;
        int                      off;
        int                      d;
        tname = "mem_fill";
        for (i = 0; i < FILL_DWORDS; i++) begin
            op      = make_mem(1'b1, lsu_pipe_pkg::f3_sd, 64'(i * 8), 1'b1);
            op.src2 = fill_word(i);
            issue(op);
        end
        tname = "mem_store";   // one doubleword per store size
        for (f3 = 0; f3 < 4; f3++) begin
            for (off = 0; off < 8; off += (1 << f3)) begin
                issue(make_mem(1'b1, 3'(f3), 64'((4 + f3) * 8 + off), 1'b0));
            end
        end
        tname = "mem_load";
        for (d = 4; d < 8; d++) begin
            for (f3 = 0; f3 < 7; f3++) begin
                for (off = 0; off < 8; off += (1 << f3[1:0])) begin
                    issue(make_mem(1'b0, 3'(f3), 64'(d * 8 + off), 1'b1));
                end
            end
        end
        tname = "mem_st_ld";
        repeat (16) begin
            r = rand64();
            issue(make_mem(1'b1, {1'b0, r[1:0]}, {58'd1, r[5:3], 3'd0} + r[8:6], 1'b0));
            issue(make_mem(1'b0, (r[11:9] == 3'd7) ? lsu_pipe_pkg::f3_ld : r[11:9],
                           {58'd1, r[5:3], 3'd0} + r[14:12], 1'b1));
        end
        drain();
    endtask

    task automatic test_link();
        lsu_pipe_pkg::issue_op_t op;
        logic [63:0]             r;
        tname = "link";
        repeat (4) begin
            r = rand64();
            issue(make_alu(r[2:0], r[3], lsu_pipe_pkg::wsel_pc4));
        end
        op          = make_mem(1'b1, lsu_pipe_pkg::f3_sw, 64'd72, 1'b1);
        op.wreg_sel = lsu_pipe_pkg::wsel_pc4;   // store with rd enable asked for
        issue(op);
        drain();
    endtask

    task automatic test_backpressure();
        logic [63:0] r;
        int          i;
        tname = "backpressure";
        for (i = 0; i < BP_OPS; i++) begin
            r = rand64();
            case (r[1:0])
                2'd0: bp_ops[i] = make_alu(r[4:2], r[5], lsu_pipe_pkg::wsel_alu);
                2'd1: bp_ops[i] = make_mem(1'b0, (r[4:2] == 3'd7) ? lsu_pipe_pkg::f3_ld : r[4:2],
                                           {55'd0, r[16:8]}, 1'b1);
                2'd2: bp_ops[i] = make_mem(1'b1, {1'b0, r[3:2]}, {55'd0, r[16:8]}, 1'b0);
                default: bp_ops[i] = make_alu(r[4:2], r[5], lsu_pipe_pkg::wsel_pc4);
            endcase
            bp_gap[i] = (r[7:6] == 2'd0) ? int'(r[9:8]) : 0;   // idle issue cycles
        end
        bp_on <= 1'b1;
        for (i = 0; i < BP_OPS; i++) begin
            if (bp_gap[i] != 0) begin
                issue_valid <= 1'b0;
                repeat (bp_gap[i]) @(posedge clk);
            end
            issue(bp_ops[i]);
        end
        bp_on <= 1'b0;
        drain();
        tname = "readback";
        for (i = 0; i < FILL_DWORDS; i++) begin
            issue(make_mem(1'b0, lsu_pipe_pkg::f3_ld, 64'(i * 8), 1'b1));
        end
        drain();
    endtask

    // retire_ready toggles only during the back-pressure test
    always @(posedge clk) begin
        if (bp_on) begin
            rnd_bit = $random(seed);
            retire_ready <= rnd_bit[0];
        end else begin
            retire_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && retire_valid && retire_ready) begin
            assert (exp_q.size() != 0) else begin
                fail_run("a record retired with no operation outstanding");
            end
            exp_rec = exp_q.pop_front();
            check_value("pc", exp_rec.pc, retire.pc);
            check_value("rd", 64'(exp_rec.rd), 64'(retire.rd));
            check_value("reg_wen", 64'(exp_rec.reg_wen), 64'(retire.reg_wen));
            check_value("wdata", exp_rec.wdata, retire.wdata);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) fail_run("timeout, the pipeline stopped retiring operations");
    end

    initial begin
        seed         = 32'hca0e7a65;
        clk          = 1'b0;
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = '0;
        retire_ready = 1'b1;
        bp_on        = 1'b0;
        pc_next      = 64'h8000_0000;
        cycles       = 0;
        test_reset();
        test_alu();
        test_mem();
        test_link();
        test_backpressure();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/lsu_pipe_pkg.sv
rtl/ex_stage.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/lsu_pipe_top.sv
dv/tb_lsu_pipe.sv

// ==== Bender.yml ====
package:
  name: lsu_pipe

dependencies: {}

sources:
  - files:
      - rtl/lsu_pipe_pkg.sv
      - rtl/ex_stage.sv
      - rtl/data_ram.sv
      - rtl/mem_stage.sv
      - rtl/wb_stage.sv
      - rtl/lsu_pipe_top.sv
  - target: test
    files:
      - dv/tb_lsu_pipe.sv
